//--- project.f
+incdir+include
src/hist_pkg.sv
src/ram_tdp.sv
src/hist_update_pipe.sv
src/hist_controller.sv
src/histogram_top.sv
tests/histogram_tb.sv

//--- Makefile
SIM      := verilator
TOP      := histogram_tb
FILELIST := project.f
OBJ_DIR  := obj_dir
FLAGS    := --binary --timing -Wno-fatal --top-module $(TOP) --Mdir $(OBJ_DIR)

.PHONY: all compile run clean

all: run

# Build the simulation binary from the file list
compile:
	$(SIM) $(FLAGS) -f $(FILELIST)

# A failing check ends in $fatal, which gives a non-zero exit status
run: compile
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

//--- include/hist_tb_table.svh
`ifndef HIST_TB_TABLE_SVH
`define HIST_TB_TABLE_SVH

// Columns: operation, bin, repeat count, expected count (-1 means model only)
localparam int NUM_ROWS = 14;

function automatic row_t table_row(input int idx);
  row_t r;
  case (idx)
    0:       r = '{OP_READ,      0,  64,   0};  // Every bin zero after reset
    1:       r = '{OP_SAMPLES,   5,  20,  -1};  // Same bin, no gaps
    2:       r = '{OP_READ,      5,   1,  20};
    3:       r = '{OP_SAMPLES,   6,   1,  -1};
    4:       r = '{OP_SAMPLES,   7,   3,  -1};
    5:       r = '{OP_READ,      4,   4,  -1};
    6:       r = '{OP_RANDOM,    0, 400,  -1};  // All bins, repeats mixed in
    7:       r = '{OP_READ,      0,  64,  -1};
    8:       r = '{OP_SAMPLES,  40, 300,  -1};  // Runs into saturation
    9:       r = '{OP_READ,     40,   1, 255};
    10:      r = '{OP_CLEAR,    12,  16,  -1};
    11:      r = '{OP_READ,      0,  64,   0};
    12:      r = '{OP_READ_BUSY, 33,  5,   5};
    13:      r = '{OP_READ,     33,   2,  -1};  // Neighbour bin got the side samples
    default: r = '{OP_READ,      0,   0,  -1};
  endcase
  return r;
endfunction

`endif

//--- tests/histogram_tb.sv
`timescale 1ns/1ns

module histogram_tb;

  typedef logic [hist_pkg::BIN_ADDR_WIDTH-1:0] bin_t;
  typedef logic [hist_pkg::COUNT_WIDTH-1:0] count_t;

  // Table operations
  typedef enum int {OP_SAMPLES, OP_RANDOM, OP_CLEAR, OP_READ, OP_READ_BUSY} op_t;

  typedef struct packed {
    op_t op;
    int  bin;
    int  reps;
    int  expected;
  } row_t;

  `include "hist_tb_table.svh"

  localparam int CLEAR_TIMEOUT = hist_pkg::NUM_BINS + 8;
  localparam int READ_TIMEOUT  = 16;

  logic                clk;
  logic                reset;
  logic                sample_valid;
  bin_t                sample_bin;
  hist_pkg::hist_cmd_t cmd;
  bin_t                cmd_bin;
  logic                busy;
  logic                read_valid;
  count_t              read_count;

  // Reference counters
  count_t model [hist_pkg::NUM_BINS];

  histogram_top i_histogram_top (
    .clk          (clk),
    .reset        (reset),
    .sample_valid (sample_valid),
    .sample_bin   (sample_bin),
    .cmd          (cmd),
    .cmd_bin      (cmd_bin),
    .busy         (busy),
    .read_valid   (read_valid),
    .read_count   (read_count)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  ////////////////////////////////////////
  // Error reporting and compares
  ////////////////////////////////////////

  task automatic stop_with_error(input string line);
    $display("%s", line);
    $display("Simulation failed");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_count(input count_t got, input count_t exp, input bin_t b);
    if (got !== exp) begin
      stop_with_error($sformatf("FAIL @%0t: bin %0d read %0d, expected %0d",
                                $time, b, got, exp));
    end
  endtask

  task automatic check_busy(input logic got, input logic exp);
    if (got !== exp) begin
      stop_with_error($sformatf("FAIL @%0t: busy is %b, expected %b", $time, got, exp));
    end
  endtask

  task automatic check_read_valid(input logic got, input logic exp);
    if (got !== exp) begin
      stop_with_error($sformatf("FAIL @%0t: read_valid is %b, expected %b",
                                $time, got, exp));
    end
  endtask

  ////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////

  // Counter holds at full scale
  function automatic void bump_model(input bin_t b);
    if (model[b] != hist_pkg::COUNT_MAX) begin
      model[b] = model[b] + count_t'(1);
    end
  endfunction

  function automatic void clear_model();
    for (int i = 0; i < hist_pkg::NUM_BINS; i++) begin
      model[i] = '0;
    end
  endfunction

  ////////////////////////////////////////
  // Stimulus tasks
  ////////////////////////////////////////

  task automatic idle_cycles(input int n);
    repeat (n) @(posedge clk);
  endtask

  // One sample per cycle, random bins keep the previous bin one time in four
  task automatic send_samples(input bin_t first, input int count, input bit random_bins);
    bin_t pick;
    pick = first;
    for (int i = 0; i < count; i++) begin
      if (random_bins && ($urandom % 4) != 0) begin
        pick = bin_t'($urandom);
      end
      @(posedge clk);
      sample_valid <= 1'b1;
      sample_bin   <= pick;
      bump_model(pick);
    end
    @(posedge clk);
    sample_valid <= 1'b0;
  endtask

  // Busy must fall and no read data may show up meanwhile
  task automatic wait_clear_done();
    int waited;
    waited = 0;
    do begin
      @(negedge clk);
      waited++;
      check_read_valid(read_valid, 1'b0);
    end while (busy && waited < CLEAR_TIMEOUT);
    if (busy) begin
      stop_with_error("Timeout: busy stayed high after a clear sweep");
    end
  endtask

  task automatic run_clear(input bin_t drop_bin, input int drops, input bit read_during);
    @(negedge clk);
    check_busy(busy, 1'b0);
    @(posedge clk);
    cmd          <= hist_pkg::CMD_CLEAR;
    // Sample in the clear cycle is lost too
    sample_valid <= 1'b1;
    sample_bin   <= drop_bin;
    @(posedge clk);
    cmd     <= read_during ? hist_pkg::CMD_READ : hist_pkg::CMD_NONE;
    cmd_bin <= drop_bin;
    @(negedge clk);
    check_busy(busy, 1'b1);
    for (int i = 1; i < drops; i++) begin
      @(posedge clk);
      cmd <= hist_pkg::CMD_NONE;
      // Sweep still running, a host read sent now stays silent
      @(negedge clk);
      check_busy(busy, 1'b1);
      check_read_valid(read_valid, 1'b0);
    end
    @(posedge clk);
    cmd          <= hist_pkg::CMD_NONE;
    sample_valid <= 1'b0;
    clear_model();
    wait_clear_done();
  endtask

  // Optional side samples to the next bin go out with the read and after it
  task automatic read_bin(input bin_t b, input int side_samples, output count_t value);
    int   waited;
    bin_t side;
    side = b + bin_t'(1);
    @(posedge clk);
    cmd     <= hist_pkg::CMD_READ;
    cmd_bin <= b;
    if (side_samples > 0) begin
      sample_valid <= 1'b1;
      sample_bin   <= side;
      bump_model(side);
    end
    for (int i = 1; i < side_samples; i++) begin
      @(posedge clk);
      cmd <= hist_pkg::CMD_NONE;
      bump_model(side);
    end
    @(posedge clk);
    cmd          <= hist_pkg::CMD_NONE;
    sample_valid <= 1'b0;
    waited = 0;
    do begin
      @(negedge clk);
      waited++;
    end while (!read_valid && waited < READ_TIMEOUT);
    if (!read_valid) begin
      stop_with_error($sformatf("Timeout: no read_valid for bin %0d", b));
    end else begin
      value = read_count;
    end
  endtask

  task automatic read_range(input bin_t first, input int n, input int expected);
    count_t value;
    bin_t   b;
    for (int i = 0; i < n; i++) begin
      b = first + bin_t'(i);
      // Let the pipeline drain first
      idle_cycles(3);
      read_bin(b, 0, value);
      check_count(value, model[b], b);
      if (expected >= 0) begin
        check_count(value, count_t'(expected), b);
      end
    end
  endtask

  ////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////
  initial begin
    row_t   row;
    count_t value;
    void'($urandom(32'he6a0ad03));
    clear_model();
    reset        <= 1'b1;
    sample_valid <= 1'b0;
    sample_bin   <= '0;
    cmd          <= hist_pkg::CMD_NONE;
    cmd_bin      <= '0;
    repeat (10) @(posedge clk);
    reset <= 1'b0;

    // Sweep starts on its own after reset
    @(negedge clk);
    check_busy(busy, 1'b1);
    wait_clear_done();

    for (int r = 0; r < NUM_ROWS; r++) begin
      row = table_row(r);
      case (row.op)
        OP_SAMPLES: send_samples(bin_t'(row.bin), row.reps, 1'b0);
        OP_RANDOM:  send_samples(bin_t'(row.bin), row.reps, 1'b1);
        OP_CLEAR:   run_clear(bin_t'(row.bin), row.reps, 1'b0);
        OP_READ:    read_range(bin_t'(row.bin), row.reps, row.expected);
        OP_READ_BUSY: begin
          run_clear(bin_t'(row.bin), 4, 1'b1);
          send_samples(bin_t'(row.bin), row.reps, 1'b0);
          idle_cycles(3);
          // Read parked behind three samples to the neighbour bin
          read_bin(bin_t'(row.bin), 3, value);
          check_count(value, model[row.bin], bin_t'(row.bin));
          check_count(value, count_t'(row.expected), bin_t'(row.bin));
        end
        default: idle_cycles(1);
      endcase
    end

    $display("Simulation passed");
    $finish;
  end

endmodule

//--- src/histogram_top.sv
`timescale 1ns/1ns

module histogram_top (
  input  logic                               clk,
  input  logic                               reset,

  // Samples
  input  logic                               sample_valid,
  input  logic [hist_pkg::BIN_ADDR_WIDTH-1:0] sample_bin,

  // Host
  input  hist_pkg::hist_cmd_t                cmd,
  input  logic [hist_pkg::BIN_ADDR_WIDTH-1:0] cmd_bin,
  output logic                               busy,
  output logic                               read_valid,
  output logic [hist_pkg::COUNT_WIDTH-1:0]    read_count
);

  // Controller to pipeline
  logic                               accept_valid;
  logic [hist_pkg::BIN_ADDR_WIDTH-1:0] accept_bin;

  // Pipeline requests
  logic                               rd_en;
  logic [hist_pkg::BIN_ADDR_WIDTH-1:0] rd_bin;
  logic                               wr_en;
  logic [hist_pkg::BIN_ADDR_WIDTH-1:0] wr_bin;
  logic [hist_pkg::COUNT_WIDTH-1:0]    wr_count;

  // RAM ports
  logic                               ram_a_enable;
  logic [hist_pkg::BIN_ADDR_WIDTH-1:0] ram_a_address;
  logic [hist_pkg::COUNT_WIDTH-1:0]    ram_a_data_egr;
  logic                               ram_b_enable;
  logic                               ram_b_write_enable;
  logic [hist_pkg::BIN_ADDR_WIDTH-1:0] ram_b_address;
  logic [hist_pkg::COUNT_WIDTH-1:0]    ram_b_data_ing;

  hist_controller i_hist_controller (
    .clk                (clk),
    .reset              (reset),
    .sample_valid       (sample_valid),
    .sample_bin         (sample_bin),
    .cmd                (cmd),
    .cmd_bin            (cmd_bin),
    .busy               (busy),
    .read_valid         (read_valid),
    .read_count         (read_count),
    .accept_valid       (accept_valid),
    .accept_bin         (accept_bin),
    .rd_en              (rd_en),
    .rd_bin             (rd_bin),
    .wr_en              (wr_en),
    .wr_bin             (wr_bin),
    .wr_count           (wr_count),
    .ram_a_enable       (ram_a_enable),
    .ram_a_address      (ram_a_address),
    .ram_a_data_egr     (ram_a_data_egr),
    .ram_b_enable       (ram_b_enable),
    .ram_b_write_enable (ram_b_write_enable),
    .ram_b_address      (ram_b_address),
    .ram_b_data_ing     (ram_b_data_ing)
  );

  hist_update_pipe i_hist_update_pipe (
    .clk          (clk),
    .reset        (reset),
    .accept_valid (accept_valid),
    .accept_bin   (accept_bin),
    .rd_en        (rd_en),
    .rd_bin       (rd_bin),
    .rd_count     (ram_a_data_egr),
    .wr_en        (wr_en),
    .wr_bin       (wr_bin),
    .wr_count     (wr_count)
  );

  // Port A never writes, port B read data is not used
  ram_tdp #(
    .DATA_WIDTH (hist_pkg::COUNT_WIDTH),
    .ADDR_WIDTH (hist_pkg::BIN_ADDR_WIDTH)
  ) i_ram_tdp (
    .clk                 (clk),
    .port_a_enable       (ram_a_enable),
    .port_a_write_enable (1'b0),
    .port_a_address      (ram_a_address),
    .port_a_data_ing     ('0),
    .port_a_data_egr     (ram_a_data_egr),
    .port_b_enable       (ram_b_enable),
    .port_b_write_enable (ram_b_write_enable),
    .port_b_address      (ram_b_address),
    .port_b_data_ing     (ram_b_data_ing),
    .port_b_data_egr     ()
  );

endmodule

//--- src/hist_controller.sv
`timescale 1ns/1ns

module hist_controller (
  input  logic                               clk,
  input  logic                               reset,

  // Sample input
  input  logic                               sample_valid,
  input  logic [hist_pkg::BIN_ADDR_WIDTH-1:0] sample_bin,

  // Host side
  input  hist_pkg::hist_cmd_t                cmd,
  input  logic [hist_pkg::BIN_ADDR_WIDTH-1:0] cmd_bin,
  output logic                               busy,
  output logic                               read_valid,
  output logic [hist_pkg::COUNT_WIDTH-1:0]    read_count,

  // Update pipeline
  output logic                               accept_valid,
  output logic [hist_pkg::BIN_ADDR_WIDTH-1:0] accept_bin,
  input  logic                               rd_en,
  input  logic [hist_pkg::BIN_ADDR_WIDTH-1:0] rd_bin,
  input  logic                               wr_en,
  input  logic [hist_pkg::BIN_ADDR_WIDTH-1:0] wr_bin,
  input  logic [hist_pkg::COUNT_WIDTH-1:0]    wr_count,

  // RAM port A, reads only
  output logic                               ram_a_enable,
  output logic [hist_pkg::BIN_ADDR_WIDTH-1:0] ram_a_address,
  input  logic [hist_pkg::COUNT_WIDTH-1:0]    ram_a_data_egr,

  // RAM port B, writes only
  output logic                               ram_b_enable,
  output logic                               ram_b_write_enable,
  output logic [hist_pkg::BIN_ADDR_WIDTH-1:0] ram_b_address,
  output logic [hist_pkg::COUNT_WIDTH-1:0]    ram_b_data_ing
);

  hist_pkg::hist_state_t state;

  // Sweep address during a clear
  logic [hist_pkg::BIN_ADDR_WIDTH-1:0] clear_addr;

  // Bin of a host read waiting for a free port A cycle
  logic [hist_pkg::BIN_ADDR_WIDTH-1:0] pend_bin;

  logic                               clearing;
  logic                               clear_req;
  logic                               host_read_issue;
  logic [hist_pkg::BIN_ADDR_WIDTH-1:0] host_read_bin;

  ////////////////////////////////////////
  // Gating and port A arbitration
  ////////////////////////////////////////

  assign clearing  = (state == hist_pkg::ST_CLEAR);
  assign clear_req = (cmd == hist_pkg::CMD_CLEAR);
  assign busy      = clearing;

  // Samples dropped while clearing or on the clear request itself
  assign accept_valid = sample_valid && !clearing && !clear_req;
  assign accept_bin   = sample_bin;

  // Host read only goes out in a cycle with no sample
  assign host_read_issue = !accept_valid && !clear_req &&
                           ((state == hist_pkg::ST_READ_PENDING) ||
                            (state == hist_pkg::ST_IDLE && cmd == hist_pkg::CMD_READ));
  assign host_read_bin   = (state == hist_pkg::ST_READ_PENDING) ? pend_bin : cmd_bin;

  // Pipeline read wins port A
  assign ram_a_enable  = rd_en || host_read_issue;
  assign ram_a_address = rd_en ? rd_bin : host_read_bin;

  ////////////////////////////////////////
  // Port B, sweep zeros or pipeline write
  ////////////////////////////////////////

  assign ram_b_enable       = clearing || wr_en;
  assign ram_b_write_enable = clearing || wr_en;
  assign ram_b_address      = clearing ? clear_addr : wr_bin;
  assign ram_b_data_ing     = clearing ? '0 : wr_count;

  // Read data comes straight from port A, qualified by read_valid
  assign read_count = ram_a_data_egr;

  ////////////////////////////////////////
  // State machine
  ////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (reset) begin
      state      <= hist_pkg::ST_CLEAR;
      clear_addr <= '0;
      read_valid <= 1'b0;
    end else begin
      // Data shows up one cycle after the host read
      read_valid <= host_read_issue;

      if (clear_req) begin
        // Clear restarts from bin 0, any pending read is dropped
        state      <= hist_pkg::ST_CLEAR;
        clear_addr <= '0;
      end else begin
        case (state)
          hist_pkg::ST_CLEAR: begin
            clear_addr <= clear_addr + 1'b1;
            if (int'(clear_addr) == hist_pkg::NUM_BINS - 1) begin
              state <= hist_pkg::ST_IDLE;
            end
          end
          hist_pkg::ST_IDLE: begin
            // Port A taken by a sample, park the read
            if (cmd == hist_pkg::CMD_READ && accept_valid) begin
              state <= hist_pkg::ST_READ_PENDING;
            end
          end
          hist_pkg::ST_READ_PENDING: begin
            if (host_read_issue) begin
              state <= hist_pkg::ST_IDLE;
            end
          end
          default: begin
            state <= hist_pkg::ST_IDLE;
          end
        endcase
      end
    end
  end

  // Pending bin is captured only from idle
  always_ff @(posedge clk) begin
    if (state == hist_pkg::ST_IDLE && cmd == hist_pkg::CMD_READ) begin
      pend_bin <= cmd_bin;
    end
  end

endmodule

//--- src/hist_update_pipe.sv
`timescale 1ns/1ns

module hist_update_pipe (
  input  logic                               clk,
  input  logic                               reset,

  // Accepted sample from the controller
  input  logic                               accept_valid,
  input  logic [hist_pkg::BIN_ADDR_WIDTH-1:0] accept_bin,

  // Read request, port A
  output logic                               rd_en,
  output logic [hist_pkg::BIN_ADDR_WIDTH-1:0] rd_bin,
  input  logic [hist_pkg::COUNT_WIDTH-1:0]    rd_count,

  // Write request, port B
  output logic                               wr_en,
  output logic [hist_pkg::BIN_ADDR_WIDTH-1:0] wr_bin,
  output logic [hist_pkg::COUNT_WIDTH-1:0]    wr_count
);

  // Stage one, sample waiting for its read data
  logic                               s1_valid;
  logic [hist_pkg::BIN_ADDR_WIDTH-1:0] s1_bin;

  // Previous cycle's write, kept for forwarding
  logic                               last_wr_valid;
  logic [hist_pkg::BIN_ADDR_WIDTH-1:0] last_wr_bin;
  logic [hist_pkg::COUNT_WIDTH-1:0]    last_wr_count;

  // Stage two selection
  logic                               fwd_hit;
  logic [hist_pkg::COUNT_WIDTH-1:0]    base_count;

  ////////////////////////////////////////
  // Stage one
  ////////////////////////////////////////

  // Read is issued in the same cycle as the sample
  assign rd_en  = accept_valid;
  assign rd_bin = accept_bin;

  always_ff @(posedge clk) begin
    if (reset) begin
      s1_valid <= 1'b0;
    end else begin
      s1_valid <= accept_valid;
    end
    s1_bin <= accept_bin;
  end

  ////////////////////////////////////////
  // Stage two
  ////////////////////////////////////////

  // RAM returned the old word if the previous sample hit the same bin
  assign fwd_hit    = last_wr_valid && (last_wr_bin == s1_bin);
  assign base_count = fwd_hit ? last_wr_count : rd_count;

  // Increment, holding at full scale
  assign wr_en    = s1_valid;
  assign wr_bin   = s1_bin;
  assign wr_count = (base_count == hist_pkg::COUNT_MAX) ? base_count
                                                        : base_count + 1'b1;

  // Forwarding register, only valid for one cycle after a write
  always_ff @(posedge clk) begin
    if (reset) begin
      last_wr_valid <= 1'b0;
    end else begin
      last_wr_valid <= wr_en;
    end
    last_wr_bin   <= wr_bin;
    last_wr_count <= wr_count;
  end

endmodule

//--- src/ram_tdp.sv
`timescale 1ns/1ns

module ram_tdp #(
  parameter int DATA_WIDTH = 8,
  parameter int ADDR_WIDTH = 6
) (
  input  logic                  clk,

  // Port A
  input  logic                  port_a_enable,
  input  logic                  port_a_write_enable,
  input  logic [ADDR_WIDTH-1:0] port_a_address,
  input  logic [DATA_WIDTH-1:0] port_a_data_ing,
  output logic [DATA_WIDTH-1:0] port_a_data_egr,

  // Port B
  input  logic                  port_b_enable,
  input  logic                  port_b_write_enable,
  input  logic [ADDR_WIDTH-1:0] port_b_address,
  input  logic [DATA_WIDTH-1:0] port_b_data_ing,
  output logic [DATA_WIDTH-1:0] port_b_data_egr
);

  // Storage array, no reset
  logic [DATA_WIDTH-1:0] ram [2**ADDR_WIDTH-1:0];

  // Both ports writing the same word in one cycle
  logic collision;

  assign collision = port_a_write_enable && port_b_write_enable &&
                     (port_a_address == port_b_address);

  ////////////////////////////////////////
  // Port A, read-first
  ////////////////////////////////////////
  always @(posedge clk) begin
    if (port_a_enable) begin
      // Old word comes out while the new one goes in
      port_a_data_egr <= ram[port_a_address];
      if (port_a_write_enable) begin
        ram[port_a_address] <= port_a_data_ing;
      end
      // Undefined result on a write-write collision
      if (collision) begin
        port_a_data_egr <= {DATA_WIDTH{1'bx}};
      end
    end
  end

  ////////////////////////////////////////
  // Port B, read-first
  ////////////////////////////////////////
  always @(posedge clk) begin
    if (port_b_enable) begin
      port_b_data_egr <= ram[port_b_address];
      if (port_b_write_enable) begin
        ram[port_b_address] <= port_b_data_ing;
      end
      if (collision) begin
        port_b_data_egr <= {DATA_WIDTH{1'bx}};
      end
    end
  end

endmodule

//--- src/hist_pkg.sv
////////////////////////////////////////
// Histogram shared definitions
////////////////////////////////////////

package hist_pkg;

  // Bin number width, 64 bins in total
  localparam int BIN_ADDR_WIDTH = 6;
  localparam int NUM_BINS = 2 ** BIN_ADDR_WIDTH;

  // Counter width and the saturation value
  localparam int COUNT_WIDTH = 8;
  localparam logic [COUNT_WIDTH-1:0] COUNT_MAX = '1;

  // Host commands, anything but CMD_NONE is a one-cycle request
  typedef enum logic [1:0] {
    CMD_NONE  = 2'd0,
    CMD_CLEAR = 2'd1,
    CMD_READ  = 2'd2
  } hist_cmd_t;

  // Controller states
  typedef enum logic [1:0] {
    ST_CLEAR        = 2'd0,
    ST_IDLE         = 2'd1,
    ST_READ_PENDING = 2'd2
  } hist_state_t;

endpackage
